//--- compile.f
+incdir+hdl
hdl/ising_pkg.sv
hdl/phase_sampler.sv
hdl/ctrl_regs.sv
hdl/bus_arbiter.sv
hdl/spin_scanner.sv
hdl/ising_readout_top.sv
verification/ising_readout_props.sv
verification/ising_readout_tb.sv

//--- hdl/bus_arbiter.sv
// ####################
// round robin arbiter for the register bus.
// host and scanner share one select/command path,
// responses go back to the granted master only.
// ####################

module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                host_req,
    input  ising_pkg::bus_req_t host_cmd,
    output ising_pkg::bus_rsp_t host_rsp,
    input  logic                scan_req,
    input  ising_pkg::bus_req_t scan_cmd,
    output ising_pkg::bus_rsp_t scan_rsp,
    output logic                bus_sel,
    output ising_pkg::bus_req_t bus_cmd,
    input  ising_pkg::bus_rsp_t sampler_rsp,
    input  ising_pkg::bus_rsp_t regs_rsp
);

    logic                busy;        // response cycle in progress.
    logic                last_scan;   // last grant went to the scanner.
    logic                pick_scan;
    ising_pkg::bus_rsp_t merged;

    // scanner wins when alone, or when both wait and the host went last.
    assign pick_scan = scan_req && (!host_req || !last_scan);

    assign bus_sel = !busy && (host_req || scan_req);
    assign bus_cmd = pick_scan ? scan_cmd : host_cmd;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            last_scan <= 1'b1;   // host goes first.
        end else begin
            busy <= bus_sel;
            if (bus_sel) begin
                last_scan <= pick_scan;
            end
        end
    end

    // idle slaves drive zero, so a plain or merges them.
    assign merged = ising_pkg::bus_rsp_t'(sampler_rsp | regs_rsp);

    // ack comes from the arbiter, so unmapped addresses still complete.
    always_comb begin
        host_rsp = '0;
        scan_rsp = '0;
        if (busy) begin
            if (last_scan) begin
                scan_rsp.rdata = merged.rdata;
                scan_rsp.ack   = 1'b1;
            end else begin
                host_rsp.rdata = merged.rdata;
                host_rsp.ack   = 1'b1;
            end
        end
    end

endmodule

//--- hdl/ctrl_regs.sv
// ####################
// control registers.
// counter maximum and cutoff, clear strobe,
// bus read back of the config.
// ####################

`include "ising_defines.svh"

module ctrl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_sel,
    input  ising_pkg::bus_req_t   bus_cmd,
    output ising_pkg::bus_rsp_t   rsp,
    output ising_pkg::phase_cfg_t cfg,
    output logic                  clear
);

    logic is_write;
    logic is_read;

    assign is_write = bus_sel && bus_cmd.write;
    assign is_read  = bus_sel && !bus_cmd.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.cnt_max <= `DEFAULT_MAX;
            cfg.cutoff  <= `DEFAULT_CUTOFF;
            clear       <= 1'b0;
            rsp         <= '0;
        end else begin
            clear <= 1'b0;   // single cycle strobe.
            rsp   <= '0;
            case (bus_cmd.addr)
                `CFG_MAX_ADDR: begin
                    if (is_write) begin
                        cfg.cnt_max <= bus_cmd.wdata;
                    end
                    rsp.rdata <= is_read ? cfg.cnt_max : '0;
                    rsp.ack   <= bus_sel;
                end
                `CFG_CUTOFF_ADDR: begin
                    if (is_write) begin
                        cfg.cutoff <= bus_cmd.wdata;
                    end
                    rsp.rdata <= is_read ? cfg.cutoff : '0;
                    rsp.ack   <= bus_sel;
                end
                `CFG_CLEAR_ADDR: begin
                    clear   <= is_write;   // reads as zero.
                    rsp.ack <= bus_sel;
                end
                default: begin
                    rsp <= '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/ising_defines.svh
// ####################
// shared macros for the ising readout.
// spin count, widths, register map and
// reset values of the config registers.
// ####################

`ifndef ISING_DEFINES_SVH
`define ISING_DEFINES_SVH

// sizes.
`define ISING_N  8
`define ISING_DW 32

// register map, word aligned byte addresses.
`define CFG_MAX_ADDR    32'h0000_0000
`define CFG_CUTOFF_ADDR 32'h0000_0004
`define CFG_CLEAR_ADDR  32'h0000_0008
`define PHASE_ADDR_BASE 32'h0000_0100   // counter i at base + 4*i.

// config values after reset.
`define DEFAULT_MAX    32'd64
`define DEFAULT_CUTOFF 32'd32

`endif

//--- hdl/ising_pkg.sv
// ####################
// ising readout package.
// bus request and response structs,
// phase counter configuration struct.
// ####################

`include "ising_defines.svh"

package ising_pkg;

    // one bus transfer as driven by a master.
    typedef struct packed {
        logic [`ISING_DW-1:0] addr;    // byte address.
        logic                 write;   // 1 for write, 0 for read.
        logic [`ISING_DW-1:0] wdata;
    } bus_req_t;

    // slave answer, one cycle after the select strobe.
    typedef struct packed {
        logic [`ISING_DW-1:0] rdata;   // zero unless a read hit.
        logic                 ack;
    } bus_rsp_t;

    // counter limits from the control registers.
    typedef struct packed {
        logic [`ISING_DW-1:0] cnt_max;  // upper saturation point.
        logic [`ISING_DW-1:0] cutoff;   // clear value and spin threshold.
    } phase_cfg_t;

endpackage

//--- hdl/ising_readout_top.sv
// ####################
// ising readout top level.
// sampler, control registers, arbiter and
// scanner joined on one register bus.
// ####################

`include "ising_defines.svh"

module ising_readout_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                host_req,
    input  ising_pkg::bus_req_t host_req_data,
    input  logic [`ISING_N-1:0] osc_spin,
    input  logic [`ISING_N-1:0] osc_field,
    input  logic                scan_en,
    output ising_pkg::bus_rsp_t host_rsp,
    output logic [`ISING_N-1:0] spins,
    output logic                scan_done,
    output logic                scan_busy
);

    // scanner side of the arbiter.
    logic                scan_req;
    ising_pkg::bus_req_t scan_cmd;
    ising_pkg::bus_rsp_t scan_rsp;

    // shared bus.
    logic                bus_sel;
    ising_pkg::bus_req_t bus_cmd;
    ising_pkg::bus_rsp_t sampler_rsp;
    ising_pkg::bus_rsp_t regs_rsp;

    // config to the counters.
    ising_pkg::phase_cfg_t cfg;
    logic                  clear;

    phase_sampler u_sampler (
        .clk       (clk),
        .rst       (rst),
        .osc_spin  (osc_spin),
        .osc_field (osc_field),
        .cfg       (cfg),
        .clear     (clear),
        .bus_sel   (bus_sel),
        .bus_cmd   (bus_cmd),
        .rsp       (sampler_rsp)
    );

    ctrl_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .bus_sel (bus_sel),
        .bus_cmd (bus_cmd),
        .rsp     (regs_rsp),
        .cfg     (cfg),
        .clear   (clear)
    );

    bus_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_cmd    (host_req_data),
        .host_rsp    (host_rsp),
        .scan_req    (scan_req),
        .scan_cmd    (scan_cmd),
        .scan_rsp    (scan_rsp),
        .bus_sel     (bus_sel),
        .bus_cmd     (bus_cmd),
        .sampler_rsp (sampler_rsp),
        .regs_rsp    (regs_rsp)
    );

    spin_scanner u_scanner (
        .clk       (clk),
        .rst       (rst),
        .scan_en   (scan_en),
        .req       (scan_req),
        .cmd       (scan_cmd),
        .rsp       (scan_rsp),
        .spins     (spins),
        .scan_done (scan_done),
        .scan_busy (scan_busy)
    );

endmodule

//--- hdl/phase_sampler.sv
// ####################
// phase sampler.
// three stage synchronizer on the spin/field mismatch,
// one saturating up/down counter per spin,
// bus read port for the counter window.
// ####################

`include "ising_defines.svh"

module phase_sampler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ISING_N-1:0]   osc_spin,
    input  logic [`ISING_N-1:0]   osc_field,
    input  ising_pkg::phase_cfg_t cfg,
    input  logic                  clear,
    input  logic                  bus_sel,
    input  ising_pkg::bus_req_t   bus_cmd,
    output ising_pkg::bus_rsp_t   rsp
);

    localparam int N     = `ISING_N;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;
    localparam logic [`ISING_DW-1:0] WIN_END = `PHASE_ADDR_BASE + 4 * N;

    logic [N-1:0]         mismatch_s1;
    logic [N-1:0]         mismatch_s2;
    logic [N-1:0]         mismatch_s3;
    logic [`ISING_DW-1:0] phase_cnt [N];
    logic [`ISING_DW-1:0] rd_offset;
    logic [IDX_W-1:0]     rd_idx;
    logic                 rd_hit;

    // xor first, then synchronize the mismatch.
    always_ff @(posedge clk) begin
        mismatch_s1 <= osc_spin ^ osc_field;
        mismatch_s2 <= mismatch_s1;
        mismatch_s3 <= mismatch_s2;
    end

    for (genvar i = 0; i < N; i++) begin : g_cnt
        always_ff @(posedge clk) begin
            if (rst || clear) begin
                phase_cnt[i] <= cfg.cutoff;   // restart from the threshold.
            end else if (mismatch_s3[i]) begin
                if (phase_cnt[i] != '0) begin
                    phase_cnt[i] <= phase_cnt[i] - 1'b1;
                end
            end else if (phase_cnt[i] < cfg.cnt_max) begin
                phase_cnt[i] <= phase_cnt[i] + 1'b1;   // holds at max.
            end
        end
    end

    // counter window decode.
    assign rd_offset = bus_cmd.addr - `PHASE_ADDR_BASE;
    assign rd_idx    = rd_offset[IDX_W+1:2];
    assign rd_hit    = (bus_cmd.addr >= `PHASE_ADDR_BASE) && (bus_cmd.addr < WIN_END);

    // value held during the select cycle is returned one cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp <= '0;
        end else begin
            rsp <= '0;
            if (bus_sel && !bus_cmd.write && rd_hit) begin
                rsp.rdata <= phase_cnt[rd_idx];
                rsp.ack   <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/spin_scanner.sv
// ####################
// spin scanner.
// bus master reading the cutoff and every counter,
// thresholds each counter into a shadow spin vector,
// publishes the vector at the end of a scan.
// ####################

`include "ising_defines.svh"

module spin_scanner (
    input  logic                clk,
    input  logic                rst,
    input  logic                scan_en,
    output logic                req,
    output ising_pkg::bus_req_t cmd,
    input  ising_pkg::bus_rsp_t rsp,
    output logic [`ISING_N-1:0] spins,
    output logic                scan_done,
    output logic                scan_busy
);

    localparam int N     = `ISING_N;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CUTOFF,
        S_COUNT,
        S_DONE
    } state_t;

    state_t               state;
    logic [IDX_W-1:0]     idx;
    logic [`ISING_DW-1:0] cutoff_q;
    logic [N-1:0]         shadow;
    logic [N-1:0]         shadow_nxt;
    logic                 last_idx;

    assign last_idx = (idx == IDX_W'(N - 1));

    // shadow with the arriving counter folded in.
    always_comb begin
        shadow_nxt      = shadow;
        shadow_nxt[idx] = (rsp.rdata >= cutoff_q);
    end

    // one outstanding read at a time, all reads.
    assign req       = (state == S_CUTOFF) || (state == S_COUNT);
    assign cmd.write = 1'b0;
    assign cmd.wdata = '0;
    assign cmd.addr  = (state == S_CUTOFF) ? `CFG_CUTOFF_ADDR :
                       `PHASE_ADDR_BASE + (`ISING_DW'(idx) << 2);

    assign scan_busy = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            idx       <= '0;
            spins     <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    idx <= '0;
                    if (scan_en) begin
                        state <= S_CUTOFF;
                    end
                end
                S_CUTOFF: begin
                    if (rsp.ack) begin
                        state <= S_COUNT;
                    end
                end
                S_COUNT: begin
                    if (rsp.ack) begin
                        idx <= idx + 1'b1;
                        if (last_idx) begin
                            spins     <= shadow_nxt;   // publish whole vector.
                            scan_done <= 1'b1;
                            state     <= S_DONE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;   // busy drops one cycle after done.
                end
            endcase
        end
    end

    // payload captures.
    always_ff @(posedge clk) begin
        if (state == S_CUTOFF && rsp.ack) begin
            cutoff_q <= rsp.rdata;
        end
        if (state == S_COUNT && rsp.ack) begin
            shadow <= shadow_nxt;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ising readout testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ising_readout_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vising_readout_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" <<< "$out"; then
    exit 0
fi
exit 1

//--- verification/ising_readout_props.sv
// ####################
// bus assertions for the register arbiter.
// ack exclusivity, select spacing,
// one ack per select, bounded wait.
// ####################

module ising_readout_props (
    input logic                clk,
    input logic                rst,
    input logic                host_req,
    input logic                scan_req,
    input logic                bus_sel,
    input ising_pkg::bus_rsp_t host_rsp,
    input ising_pkg::bus_rsp_t scan_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [2:0] host_wait;   // cycles a host request has gone without ack.
    logic [2:0] scan_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            host_wait <= '0;
            scan_wait <= '0;
        end else begin
            host_wait <= (host_req && !host_rsp.ack) ? host_wait + 3'd1 : 3'd0;
            scan_wait <= (scan_req && !scan_rsp.ack) ? scan_wait + 3'd1 : 3'd0;
        end
    end

    a_ack_excl: assert property (@(posedge clk) disable iff (rst)
        !(host_rsp.ack && scan_rsp.ack))
        else $error("both masters acknowledged in one cycle");

    a_sel_gap: assert property (@(posedge clk) disable iff (rst)
        bus_sel |=> !bus_sel)
        else $error("bus_sel high in two consecutive cycles");

    a_sel_ack: assert property (@(posedge clk) disable iff (rst)
        bus_sel |=> (host_rsp.ack ^ scan_rsp.ack))
        else $error("bus_sel not followed by exactly one acknowledge");

    a_host_wait: assert property (@(posedge clk) disable iff (rst)
        host_wait < 3'd4)
        else $error("host request not granted within four cycles");

    a_scan_wait: assert property (@(posedge clk) disable iff (rst)
        scan_wait < 3'd4)
        else $error("scanner request not granted within four cycles");

endmodule

bind bus_arbiter ising_readout_props u_props (
    .clk      (clk),
    .rst      (rst),
    .host_req (host_req),
    .scan_req (scan_req),
    .bus_sel  (bus_sel),
    .host_rsp (host_rsp),
    .scan_rsp (scan_rsp)
);

//--- verification/ising_readout_tb.sv
// ####################
// testbench for the ising readout.
// clock, reset, random host traffic and oscillators,
// phase counter model, spin scan checks.
// ####################

`include "ising_defines.svh"

module ising_readout_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N          = `ISING_N;
    localparam int DW         = `ISING_DW;
    localparam int SEED       = 8159;
    localparam int CFG_OPS    = 20;
    localparam int CLR_ROUNDS = 3;
    localparam int RAND_OPS   = 300;
    localparam int SCANS      = 4;
    localparam int OP_CYC     = 6;    // host transfer under contention, with margin.
    localparam int SAT_CYC    = 32;   // max stays below 24, plus sync delay.
    localparam int SCAN_CYC   = 4 * (N + 1) + 4;
    localparam int TOTAL_CYC  = 10 + (2 + 2 * CFG_OPS) * OP_CYC
                              + CLR_ROUNDS * (2 + N) * OP_CYC + RAND_OPS * (OP_CYC + 2)
                              + 2 * SCANS * (4 * OP_CYC + SAT_CYC + SCAN_CYC);
    localparam int WD_CYC     = TOTAL_CYC * 3 / 2;

    logic                clk;
    logic                rst;
    logic                host_req;
    ising_pkg::bus_req_t host_req_data;
    logic [N-1:0]        osc_spin;
    logic [N-1:0]        osc_field;
    logic                scan_en;
    ising_pkg::bus_rsp_t host_rsp;
    logic [N-1:0]        spins;
    logic                scan_done;
    logic                scan_busy;

    // reference model state.
    logic [N-1:0]  m_s1;
    logic [N-1:0]  m_s2;
    logic [N-1:0]  m_s3;
    logic [DW-1:0] m_cnt [N];
    logic [DW-1:0] m_hist [N];   // counters during the previous cycle.
    logic [DW-1:0] m_max;
    logic [DW-1:0] m_cutoff;
    logic          m_clear;      // clear strobe seen on the bus this cycle.

    integer seed;
    integer osc_seed;
    logic   rand_osc;
    logic   scan_finished;

    ising_readout_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .host_req      (host_req),
        .host_req_data (host_req_data),
        .osc_spin      (osc_spin),
        .osc_field     (osc_field),
        .scan_en       (scan_en),
        .host_rsp      (host_rsp),
        .spins         (spins),
        .scan_done     (scan_done),
        .scan_busy     (scan_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // sync chain and saturating counters, one step per edge.
    always @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            m_hist[i] = m_cnt[i];
            if (rst || m_clear) begin
                m_cnt[i] = m_cutoff;
            end else if (m_s3[i]) begin
                if (m_cnt[i] != '0) m_cnt[i] = m_cnt[i] - 1'b1;
            end else if (m_cnt[i] < m_max) begin
                m_cnt[i] = m_cnt[i] + 1'b1;
            end
        end
        m_clear = 1'b0;
        m_s3 = m_s2;
        m_s2 = m_s1;
        m_s1 = osc_spin ^ osc_field;
    end

    always @(negedge clk) begin
        if (rand_osc) begin
            osc_spin  = N'($random(osc_seed));
            osc_field = N'($random(osc_seed));
        end
    end

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1, "stopping after the first error");
    endtask

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", WD_CYC);
        fail_run();
    end

    function automatic logic [DW-1:0] rnd(input int unsigned range);
        return $unsigned($random(seed)) % range;
    endfunction

    task automatic check_rsp(input string name, input ising_pkg::bus_rsp_t exp,
                             input ising_pkg::bus_rsp_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_spins(input logic [N-1:0] exp, input logic [N-1:0] act);
        if (act !== exp) begin
            $display("Error at %0t: spins expected %b got %b", $time, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    // one host transfer, starting and ending on a falling edge.
    task automatic bus_xfer(input logic [DW-1:0] addr, input logic wr,
                            input logic [DW-1:0] wdata, output ising_pkg::bus_rsp_t rsp);
        host_req_data.addr  = addr;
        host_req_data.write = wr;
        host_req_data.wdata = wdata;
        host_req = 1'b1;
        @(negedge clk);
        while (!host_rsp.ack) @(negedge clk);
        rsp = host_rsp;
        host_req = 1'b0;
    endtask

    task automatic write_reg(input logic [DW-1:0] addr, input logic [DW-1:0] data);
        ising_pkg::bus_rsp_t rsp;
        bus_xfer(addr, 1'b1, data, rsp);
        check_rsp("host_rsp (write)", '{rdata: '0, ack: 1'b1}, rsp);
        if (addr == `CFG_MAX_ADDR) m_max = data;
        if (addr == `CFG_CUTOFF_ADDR) m_cutoff = data;
        if (addr == `CFG_CLEAR_ADDR) m_clear = 1'b1;   // counters reload next edge.
    endtask

    task automatic read_reg(input logic [DW-1:0] addr);
        ising_pkg::bus_rsp_t rsp;
        logic [DW-1:0]       exp;
        int                  idx;
        bus_xfer(addr, 1'b0, '0, rsp);
        exp = '0;
        if (addr == `CFG_MAX_ADDR) exp = m_max;
        if (addr == `CFG_CUTOFF_ADDR) exp = m_cutoff;
        if (addr >= `PHASE_ADDR_BASE && addr < `PHASE_ADDR_BASE + 4 * N) begin
            idx = int'((addr - `PHASE_ADDR_BASE) >> 2);
            exp = m_hist[idx];   // value at the grant cycle.
        end
        check_rsp("host_rsp.rdata", '{rdata: exp, ack: 1'b1}, rsp);
    endtask

    task automatic run_scan(input logic [N-1:0] exp);
        check_flag("scan_busy", 1'b0, scan_busy);
        scan_en = 1'b1;
        @(negedge clk);
        while (!scan_done) begin
            check_flag("scan_busy", 1'b1, scan_busy);
            @(negedge clk);
        end
        check_flag("scan_busy", 1'b1, scan_busy);
        scan_en = 1'b0;
        check_spins(exp, spins);
        @(negedge clk);
        check_flag("scan_done", 1'b0, scan_done);   // single cycle pulse.
        check_flag("scan_busy", 1'b0, scan_busy);
    endtask

    // settle a fixed pattern, then scan with or without host reads.
    task automatic saturate_and_scan(input logic host_traffic);
        logic [DW-1:0] mx;
        logic [DW-1:0] co;
        logic [N-1:0]  pat;
        mx = 4 + rnd(20);
        co = 1 + rnd(mx - 1);
        write_reg(`CFG_MAX_ADDR, mx);
        write_reg(`CFG_CUTOFF_ADDR, co);
        write_reg(`CFG_CLEAR_ADDR, '0);
        pat       = N'($random(seed));
        osc_spin  = N'($random(seed));
        osc_field = osc_spin ^ pat;   // set bits mismatch.
        repeat (SAT_CYC) @(negedge clk);
        if (host_traffic) begin
            scan_finished = 1'b0;
            fork
                begin
                    run_scan(~pat);
                    scan_finished = 1'b1;
                end
                begin
                    while (!scan_finished) read_reg(`PHASE_ADDR_BASE + (rnd(N) << 2));
                end
            join
        end else begin
            run_scan(~pat);
        end
    endtask

    initial begin
        seed          = SEED;
        osc_seed      = SEED;
        rst           = 1'b1;
        host_req      = 1'b0;
        host_req_data = '0;
        osc_spin      = '0;
        osc_field     = '0;
        scan_en       = 1'b0;
        rand_osc      = 1'b0;
        scan_finished = 1'b0;
        m_s1          = '0;
        m_s2          = '0;
        m_s3          = '0;
        m_clear       = 1'b0;
        m_max         = `DEFAULT_MAX;
        m_cutoff      = `DEFAULT_CUTOFF;
        repeat (10) @(negedge clk);
        rst      = 1'b0;
        rand_osc = 1'b1;

        // outputs low out of reset.
        check_rsp("host_rsp", '0, host_rsp);
        check_flag("scan_busy", 1'b0, scan_busy);
        check_flag("scan_done", 1'b0, scan_done);
        check_spins('0, spins);

        // defaults and config read back.
        read_reg(`CFG_MAX_ADDR);
        read_reg(`CFG_CUTOFF_ADDR);
        for (int k = 0; k < CFG_OPS; k++) begin
            if (rnd(2) == 0) begin
                write_reg(`CFG_MAX_ADDR, $random(seed));
                read_reg(`CFG_MAX_ADDR);
            end else begin
                write_reg(`CFG_CUTOFF_ADDR, $random(seed));
                read_reg(`CFG_CUTOFF_ADDR);
            end
        end

        // clear reloads the cutoff.
        write_reg(`CFG_MAX_ADDR, 8 + rnd(24));
        for (int r = 0; r < CLR_ROUNDS; r++) begin
            write_reg(`CFG_CUTOFF_ADDR, rnd(m_max + 1));
            write_reg(`CFG_CLEAR_ADDR, '0);
            for (int i = 0; i < N; i++) begin
                read_reg(`PHASE_ADDR_BASE + DW'(4 * i));
            end
        end

        // random traffic with small maxima to hit both rails.
        for (int k = 0; k < RAND_OPS; k++) begin
            case (rnd(16))
                0: write_reg(`CFG_MAX_ADDR, 1 + rnd(6));
                1: write_reg(`CFG_CUTOFF_ADDR, rnd(m_max + 1));
                2: write_reg(`CFG_CLEAR_ADDR, '0);
                3: read_reg(rnd(2) == 0 ? `CFG_MAX_ADDR : `CFG_CUTOFF_ADDR);
                default: read_reg(`PHASE_ADDR_BASE + (rnd(N) << 2));
            endcase
            repeat (rnd(3)) @(negedge clk);
        end

        rand_osc = 1'b0;
        for (int s = 0; s < SCANS; s++) saturate_and_scan(1'b0);
        for (int s = 0; s < SCANS; s++) saturate_and_scan(1'b1);

        $display("=== PASS ===");
        $finish;
    end

endmodule
